//--- src/pmp_pkg.sv
// Shared constants, CSR map and cfg word type for the PMP unit, imported by every PMP block
package pmp_pkg;

  // Region count and granularity (G=2 gives 16-byte granules)
  localparam int PMP_NUM_REGIONS   = 8;
  localparam int PMP_GRANULARITY   = 2;
  localparam int PMP_NUM_CFG_WORDS = 2;

  // CSR addresses
  localparam logic [11:0] CSR_PMPCFG0  = 12'h3A0;
  localparam logic [11:0] CSR_PMPADDR0 = 12'h3B0;
  localparam logic [11:0] CSR_MSECCFG  = 12'h747;

  // Addresses that are M-mode only, implemented or not
  localparam logic [11:0] CSR_PMP_RANGE_LO = 12'h3A0;
  localparam logic [11:0] CSR_PMP_RANGE_HI = 12'h3EF;
  localparam logic [11:0] CSR_MSECCFGH     = 12'h757;

  // Bit positions inside one cfg byte
  localparam int CFG_R_BIT = 0;
  localparam int CFG_W_BIT = 1;
  localparam int CFG_X_BIT = 2;
  localparam int CFG_A_LO  = 3;
  localparam int CFG_L_BIT = 7;

  // Address matching modes in cfg bits 4:3
  localparam logic [1:0] PMP_MODE_OFF   = 2'b00;
  localparam logic [1:0] PMP_MODE_TOR   = 2'b01;
  localparam logic [1:0] PMP_MODE_NA4   = 2'b10;
  localparam logic [1:0] PMP_MODE_NAPOT = 2'b11;

  // mseccfg fields
  localparam int MSECCFG_MML_BIT = 0;
  localparam int MSECCFG_RLB_BIT = 2;

  // Privilege levels
  localparam logic [1:0] PRIV_U = 2'b00;
  localparam logic [1:0] PRIV_M = 2'b11;

  // One pmpcfg CSR, seen as a plain word or as four region bytes
  // Byte 0 belongs to the lowest region of the word
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] cfg;
  } pmpcfg_word_u;

endpackage

//--- src/pmp_state_if.sv
// Live PMP register state, driven by the CSR block and read by the access checkers
interface pmp_state_if;
  import pmp_pkg::*;

  // One cfg byte per region
  logic [PMP_NUM_REGIONS-1:0][7:0]  cfg;
  // Stored pmpaddr values, before any readback masking
  logic [PMP_NUM_REGIONS-1:0][31:0] addr;
  logic                             mml;
  logic                             rlb;

  modport regs (
    output cfg,
    output addr,
    output mml,
    output rlb
  );

  modport chk (
    input cfg,
    input addr,
    input mml,
    input rlb
  );

endinterface

//--- src/pmp_cfg_warl.sv
// WARL legalization of one pmpcfg byte, instantiated once per region by the CSR block
module pmp_cfg_warl (
  input  logic [7:0] cfg_prev_i,
  input  logic [7:0] cfg_attempt_i,
  input  logic       mml_i,
  input  logic       rlb_i,
  output logic [7:0] cfg_o
);
  import pmp_pkg::*;

  logic [3:0] lrwx_attempt;
  logic       exec_locked;

  assign lrwx_attempt = {cfg_attempt_i[CFG_L_BIT], cfg_attempt_i[CFG_R_BIT],
                         cfg_attempt_i[CFG_W_BIT], cfg_attempt_i[CFG_X_BIT]};

  // Locked patterns with execute that machine mode may not create under MML
  assign exec_locked = (lrwx_attempt == 4'b1001) || (lrwx_attempt == 4'b1010) ||
                       (lrwx_attempt == 4'b1011) || (lrwx_attempt == 4'b1101);

  always_comb begin
    cfg_o = cfg_attempt_i;

    // W without R is reserved outside MML
    if (cfg_attempt_i[CFG_W_BIT] && !cfg_attempt_i[CFG_R_BIT] && !mml_i) begin
      cfg_o[CFG_X_BIT:CFG_R_BIT] = cfg_prev_i[CFG_X_BIT:CFG_R_BIT];
    end

    // NA4 cannot exist with G above zero
    if (cfg_attempt_i[CFG_A_LO +: 2] == PMP_MODE_NA4) begin
      cfg_o[CFG_A_LO +: 2] = cfg_prev_i[CFG_A_LO +: 2];
    end

    if (cfg_prev_i[CFG_L_BIT] && !rlb_i) begin
      cfg_o = cfg_prev_i;
    end

    if (mml_i && !rlb_i && exec_locked) begin
      cfg_o = cfg_prev_i;
    end

    // Reserved bits
    cfg_o[6:5] = 2'b00;
  end

endmodule

//--- src/pmp_csr_regs.sv
// PMP CSR register block with address decode, WARL writes, lock rules and readback masking
module pmp_csr_regs (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [1:0]  priv_lvl_i,
  input  logic        csr_we_i,
  input  logic [11:0] csr_addr_i,
  input  logic [31:0] csr_wdata_i,
  output logic [31:0] csr_rdata_o,
  output logic        csr_illegal_o,
  pmp_state_if.regs   state_o
);
  import pmp_pkg::*;

  logic [PMP_NUM_REGIONS-1:0][7:0]  cfg_q;
  logic [PMP_NUM_REGIONS-1:0][31:0] addr_q;
  logic                             mml_q;
  logic                             rlb_q;

  logic [PMP_NUM_REGIONS-1:0][7:0]  cfg_legal;
  logic [PMP_NUM_REGIONS-1:0][7:0]  cfg_above;
  logic [PMP_NUM_REGIONS-1:0][31:0] addr_rd;
  logic [PMP_NUM_REGIONS-1:0]       addr_wr_ok;
  logic                             any_locked;

  pmpcfg_word_u wdata_u;
  pmpcfg_word_u rd_cfg_u;

  logic [11:0] cfg_off;
  logic [11:0] addr_off;
  logic        cfg_hit;
  logic        addr_hit;
  logic        mseccfg_hit;
  logic        guarded;
  logic        csr_we_ok;

  // Address decode; offsets wrap for addresses below each block
  assign cfg_off     = csr_addr_i - CSR_PMPCFG0;
  assign addr_off    = csr_addr_i - CSR_PMPADDR0;
  assign cfg_hit     = cfg_off < 12'(PMP_NUM_CFG_WORDS);
  assign addr_hit    = addr_off < 12'(PMP_NUM_REGIONS);
  assign mseccfg_hit = csr_addr_i == CSR_MSECCFG;

  assign guarded = ((csr_addr_i >= CSR_PMP_RANGE_LO) && (csr_addr_i <= CSR_PMP_RANGE_HI)) ||
                   mseccfg_hit || (csr_addr_i == CSR_MSECCFGH);

  assign csr_illegal_o = guarded && (priv_lvl_i == PRIV_U);
  assign csr_we_ok     = csr_we_i && !csr_illegal_o;

  assign wdata_u.word = csr_wdata_i;

  for (genvar i = 0; i < PMP_NUM_REGIONS; i++) begin : gen_warl
    pmp_cfg_warl u_warl (
      .cfg_prev_i    (cfg_q[i]),
      .cfg_attempt_i (wdata_u.cfg[i % 4]),
      .mml_i         (mml_q),
      .rlb_i         (rlb_q),
      .cfg_o         (cfg_legal[i])
    );
  end

  // Entry above the top region is an unlocked OFF entry
  assign cfg_above = {8'h00, cfg_q[PMP_NUM_REGIONS-1:1]};

  always_comb begin
    any_locked = 1'b0;
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      any_locked = any_locked | cfg_q[i][CFG_L_BIT];
      // Own lock, or a locked TOR entry above that uses this address as its base
      addr_wr_ok[i] = rlb_q ||
                      !(cfg_q[i][CFG_L_BIT] ||
                        (cfg_above[i][CFG_L_BIT] &&
                         (cfg_above[i][CFG_A_LO +: 2] == PMP_MODE_TOR)));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q  <= '0;
      addr_q <= '0;
      mml_q  <= 1'b0;
      rlb_q  <= 1'b0;
    end else if (csr_we_ok) begin
      for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
        if (cfg_hit && (cfg_off == 12'(i / 4))) begin
          cfg_q[i] <= cfg_legal[i];
        end
        if (addr_hit && (addr_off == 12'(i)) && addr_wr_ok[i]) begin
          addr_q[i] <= csr_wdata_i;
        end
      end
      if (mseccfg_hit) begin
        // MML is sticky until reset
        mml_q <= mml_q | csr_wdata_i[MSECCFG_MML_BIT];
        if (rlb_q || !any_locked) begin
          rlb_q <= csr_wdata_i[MSECCFG_RLB_BIT];
        end
      end
    end
  end

  // Software view of pmpaddr depends on the mode of its own entry
  always_comb begin
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      addr_rd[i] = addr_q[i];
      if (cfg_q[i][CFG_A_LO + 1]) begin
        addr_rd[i][PMP_GRANULARITY-2:0] = '1;
      end else begin
        addr_rd[i][PMP_GRANULARITY-1:0] = '0;
      end
    end
  end

  always_comb begin
    rd_cfg_u.word = '0;
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      if (cfg_off == 12'(i / 4)) begin
        rd_cfg_u.cfg[i % 4] = cfg_q[i];
      end
    end
  end

  always_comb begin
    csr_rdata_o = '0;
    if (cfg_hit) begin
      csr_rdata_o = rd_cfg_u.word;
    end else if (addr_hit) begin
      for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
        if (addr_off == 12'(i)) begin
          csr_rdata_o = addr_rd[i];
        end
      end
    end else if (mseccfg_hit) begin
      csr_rdata_o[MSECCFG_MML_BIT] = mml_q;
      csr_rdata_o[MSECCFG_RLB_BIT] = rlb_q;
    end
  end

  assign state_o.cfg  = cfg_q;
  assign state_o.addr = addr_q;
  assign state_o.mml  = mml_q;
  assign state_o.rlb  = rlb_q;

endmodule

//--- src/pmp_region_match.sv
// Address match of one PMP region in OFF, TOR, NA4 or NAPOT mode
module pmp_region_match (
  input  logic [31:0] addr_i,
  input  logic [1:0]  mode_i,
  input  logic [31:0] pmpaddr_i,
  input  logic [31:0] pmpaddr_below_i,
  output logic        match_o
);
  import pmp_pkg::*;

  logic [31:0] word_addr;
  logic [31:0] tor_lo;
  logic [31:0] tor_hi;
  logic [31:0] napot_val;
  logic [31:0] napot_care;

  // pmpaddr holds address bits 33:2
  assign word_addr = {2'b00, addr_i[31:2]};

  assign tor_lo = {pmpaddr_below_i[31:PMP_GRANULARITY], {PMP_GRANULARITY{1'b0}}};
  assign tor_hi = {pmpaddr_i[31:PMP_GRANULARITY], {PMP_GRANULARITY{1'b0}}};

  always_comb begin
    napot_val = pmpaddr_i;
    if (mode_i == PMP_MODE_NA4) begin
      // One granule, same as the smallest NAPOT region
      napot_val[PMP_GRANULARITY-1] = 1'b0;
    end
    napot_val[PMP_GRANULARITY-2:0] = '1;
  end

  // Trailing ones and the zero above them are don't-care bits
  assign napot_care = ~(napot_val ^ (napot_val + 32'd1));

  always_comb begin
    unique case (mode_i)
      PMP_MODE_TOR: begin
        match_o = (word_addr >= tor_lo) && (word_addr < tor_hi);
      end
      PMP_MODE_NA4, PMP_MODE_NAPOT: begin
        match_o = (word_addr & napot_care) == (napot_val & napot_care);
      end
      default: begin
        match_o = 1'b0;
      end
    endcase
  end

endmodule

//--- src/pmp_access_check.sv
// Priority resolution over all PMP regions into R, W and X permission for one address
module pmp_access_check (
  input  logic [31:0] addr_i,
  input  logic [1:0]  priv_lvl_i,
  pmp_state_if.chk    state_i,
  output logic [2:0]  perm_o
);
  import pmp_pkg::*;

  logic [PMP_NUM_REGIONS-1:0]       match;
  logic [PMP_NUM_REGIONS-1:0][31:0] addr_below;
  logic                             hit;
  logic [7:0]                       hit_cfg;
  logic [2:0]                       region_rwx;
  logic                             is_m;

  // Region 0 starts its TOR range at zero
  assign addr_below = {state_i.addr[PMP_NUM_REGIONS-2:0], 32'h0};

  for (genvar i = 0; i < PMP_NUM_REGIONS; i++) begin : gen_match
    pmp_region_match u_match (
      .addr_i          (addr_i),
      .mode_i          (state_i.cfg[i][CFG_A_LO +: 2]),
      .pmpaddr_i       (state_i.addr[i]),
      .pmpaddr_below_i (addr_below[i]),
      .match_o         (match[i])
    );
  end

  // Walk from the top so the lowest matching index is kept
  always_comb begin
    hit     = 1'b0;
    hit_cfg = '0;
    for (int i = PMP_NUM_REGIONS - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit     = 1'b1;
        hit_cfg = state_i.cfg[i];
      end
    end
  end

  assign region_rwx = hit_cfg[CFG_X_BIT:CFG_R_BIT];
  assign is_m       = priv_lvl_i == PRIV_M;

  always_comb begin
    perm_o = '0;
    if (!state_i.mml) begin
      if (hit) begin
        // Unlocked regions do not restrict machine mode
        perm_o = (is_m && !hit_cfg[CFG_L_BIT]) ? 3'b111 : region_rwx;
      end else if (is_m) begin
        perm_o = 3'b111;
      end
    end else begin
      if (hit) begin
        // Locked rules are machine mode rules, unlocked are user mode rules
        perm_o = (hit_cfg[CFG_L_BIT] == is_m) ? region_rwx : 3'b000;
      end else if (is_m) begin
        perm_o[CFG_R_BIT] = 1'b1;
        perm_o[CFG_W_BIT] = 1'b1;
      end
    end
  end

endmodule

//--- src/pmp_unit.sv
// PMP unit top level joining the CSR register block with the fetch and data checkers
module pmp_unit (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [1:0]  priv_lvl_i,
  input  logic        csr_we_i,
  input  logic [11:0] csr_addr_i,
  input  logic [31:0] csr_wdata_i,
  output logic [31:0] csr_rdata_o,
  output logic        csr_illegal_o,
  input  logic [31:0] fetch_addr_i,
  output logic        fetch_allow_o,
  input  logic [31:0] data_addr_i,
  output logic        data_rd_allow_o,
  output logic        data_wr_allow_o
);
  import pmp_pkg::*;

  logic [2:0] fetch_perm;
  logic [2:0] data_perm;

  pmp_state_if u_state ();

  pmp_csr_regs u_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .priv_lvl_i    (priv_lvl_i),
    .csr_we_i      (csr_we_i),
    .csr_addr_i    (csr_addr_i),
    .csr_wdata_i   (csr_wdata_i),
    .csr_rdata_o   (csr_rdata_o),
    .csr_illegal_o (csr_illegal_o),
    .state_o       (u_state)
  );

  pmp_access_check u_fetch (
    .addr_i     (fetch_addr_i),
    .priv_lvl_i (priv_lvl_i),
    .state_i    (u_state),
    .perm_o     (fetch_perm)
  );

  pmp_access_check u_data (
    .addr_i     (data_addr_i),
    .priv_lvl_i (priv_lvl_i),
    .state_i    (u_state),
    .perm_o     (data_perm)
  );

  assign fetch_allow_o   = fetch_perm[CFG_X_BIT];
  assign data_rd_allow_o = data_perm[CFG_R_BIT];
  assign data_wr_allow_o = data_perm[CFG_W_BIT];

endmodule

//--- verif/tb_pmp_unit.sv
// Table-driven testbench for the PMP unit, run as the simulation top to check CSRs and permissions
module tb_pmp_unit;
  import pmp_pkg::*;

  // Entry kinds
  localparam int WR  = 0;
  localparam int RD  = 1;
  localparam int CK  = 2;
  localparam int RST = 3;
  localparam int MAX_ENTRIES = 96;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic [1:0]  priv_lvl_i;
  logic        csr_we_i;
  logic [11:0] csr_addr_i;
  logic [31:0] csr_wdata_i;
  logic [31:0] csr_rdata_o;
  logic        csr_illegal_o;
  logic [31:0] fetch_addr_i;
  logic        fetch_allow_o;
  logic [31:0] data_addr_i;
  logic        data_rd_allow_o;
  logic        data_wr_allow_o;

  // Stimulus and expected values, one slot per entry
  int          kind_tab    [MAX_ENTRIES];
  logic [1:0]  priv_tab    [MAX_ENTRIES];
  logic [11:0] csr_tab     [MAX_ENTRIES];
  logic [31:0] wdata_tab   [MAX_ENTRIES];
  logic [31:0] fetch_tab   [MAX_ENTRIES];
  logic [31:0] data_tab    [MAX_ENTRIES];
  logic [31:0] rdata_tab   [MAX_ENTRIES];
  logic        illegal_tab [MAX_ENTRIES];
  // Fetch, read and write allow bits, in that order
  logic [2:0]  allow_tab   [MAX_ENTRIES];

  int n_entries   = 0;
  int errors      = 0;
  int cycles      = 0;
  int cycle_limit = 0;

  pmp_unit dut (.*);

  initial begin
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the entry loop did not finish", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic add_row(input int kind, input logic [1:0] priv, input logic [11:0] csr,
                         input logic [31:0] wdata, input logic [31:0] fetch,
                         input logic [31:0] data, input logic [31:0] rdata,
                         input logic illegal, input logic [2:0] allow);
    if (n_entries >= MAX_ENTRIES) begin
      $display("table overflow, entry %0d does not fit", n_entries);
      errors = errors + 1;
    end else begin
      kind_tab[n_entries]    = kind;
      priv_tab[n_entries]    = priv;
      csr_tab[n_entries]     = csr;
      wdata_tab[n_entries]   = wdata;
      fetch_tab[n_entries]   = fetch;
      data_tab[n_entries]    = data;
      rdata_tab[n_entries]   = rdata;
      illegal_tab[n_entries] = illegal;
      allow_tab[n_entries]   = allow;
      n_entries = n_entries + 1;
    end
  endtask

  task automatic apply_reset();
    csr_we_i = 1'b0;
    rst_ni   = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  task automatic check_entry(input int idx);
    logic [2:0] allow;
    allow = {fetch_allow_o, data_rd_allow_o, data_wr_allow_o};
    if (csr_illegal_o !== illegal_tab[idx]) begin
      $display("mismatch at %0t: entry %0d csr %h illegal %b, expected %b",
               $time, idx, csr_tab[idx], csr_illegal_o, illegal_tab[idx]);
      errors = errors + 1;
    end
    if ((kind_tab[idx] == RD) && !illegal_tab[idx] && (csr_rdata_o !== rdata_tab[idx])) begin
      $display("mismatch at %0t: entry %0d csr %h rdata %h, expected %h",
               $time, idx, csr_tab[idx], csr_rdata_o, rdata_tab[idx]);
      errors = errors + 1;
    end
    if ((kind_tab[idx] == CK) && (allow !== allow_tab[idx])) begin
      $display("mismatch at %0t: entry %0d fetch %h data %h allow %b, expected %b",
               $time, idx, fetch_tab[idx], data_tab[idx], allow, allow_tab[idx]);
      errors = errors + 1;
    end
  endtask

  initial begin
    rst_ni       = 1'b0;
    priv_lvl_i   = PRIV_M;
    csr_we_i     = 1'b0;
    csr_addr_i   = '0;
    csr_wdata_i  = '0;
    fetch_addr_i = '0;
    data_addr_i  = '0;

    // Reset state
    add_row(RD, PRIV_M, 12'h3A0, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h3A1, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h3B7, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h747, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(CK, PRIV_M, 12'h000, 32'h0, 32'h0000_1000, 32'h8000_0000, 32'h0, 1'b0, 3'b111);
    add_row(CK, PRIV_U, 12'h000, 32'h0, 32'h0000_1000, 32'h8000_0000, 32'h0, 1'b0, 3'b000);
    // WARL and readback of region 0
    add_row(WR, PRIV_M, 12'h3B0, 32'h0000_0406, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3A0, 32'h0000_001B, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h3B0, 32'h0, 32'h0, 32'h0, 32'h0000_0407, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3A0, 32'h0000_001E, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h3A0, 32'h0, 32'h0, 32'h0, 32'h0000_001B, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3A0, 32'h0000_0015, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h3A0, 32'h0, 32'h0, 32'h0, 32'h0000_001D, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3A0, 32'h0000_000D, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h3B0, 32'h0, 32'h0, 32'h0, 32'h0000_0404, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3A0, 32'h0000_007D, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h3A0, 32'h0, 32'h0, 32'h0, 32'h0000_001D, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h3B0, 32'h0, 32'h0, 32'h0, 32'h0000_0407, 1'b0, 3'b000);
    // User mode access to guarded CSRs
    add_row(WR, PRIV_U, 12'h3A0, 32'h0000_001F, 32'h0, 32'h0, 32'h0, 1'b1, 3'b000);
    add_row(WR, PRIV_U, 12'h3B5, 32'h0000_1234, 32'h0, 32'h0, 32'h0, 1'b1, 3'b000);
    add_row(WR, PRIV_U, 12'h747, 32'h0000_0001, 32'h0, 32'h0, 32'h0, 1'b1, 3'b000);
    add_row(RD, PRIV_U, 12'h757, 32'h0, 32'h0, 32'h0, 32'h0, 1'b1, 3'b000);
    add_row(RD, PRIV_M, 12'h3A0, 32'h0, 32'h0, 32'h0, 32'h0000_001D, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h3B5, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h747, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    // NAPOT regions 1 and 3 over a TOR region 2 from 0x2000 to 0x3000
    add_row(WR, PRIV_M, 12'h3B1, 32'h0000_0801, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3B2, 32'h0000_0C00, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3B3, 32'h0000_081F, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3A0, 32'h1F0B_1C1D, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(CK, PRIV_U, 12'h000, 32'h0, 32'h0000_1000, 32'h0000_1010, 32'h0, 1'b0, 3'b110);
    add_row(CK, PRIV_U, 12'h000, 32'h0, 32'h0000_2004, 32'h0000_2004, 32'h0, 1'b0, 3'b100);
    add_row(CK, PRIV_U, 12'h000, 32'h0, 32'h0000_2040, 32'h0000_2040, 32'h0, 1'b0, 3'b011);
    add_row(CK, PRIV_U, 12'h000, 32'h0, 32'h0000_2800, 32'h0000_2FFC, 32'h0, 1'b0, 3'b011);
    add_row(CK, PRIV_U, 12'h000, 32'h0, 32'h0000_3000, 32'h0000_1040, 32'h0, 1'b0, 3'b000);
    // Lock the TOR region
    add_row(WR, PRIV_M, 12'h3A0, 32'h1F8B_1C1D, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3A0, 32'h1F0F_1C1D, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h3A0, 32'h0, 32'h0, 32'h0, 32'h1F8B_1C1D, 1'b0, 3'b000);
    add_row(CK, PRIV_M, 12'h000, 32'h0, 32'h0000_2800, 32'h0000_2800, 32'h0, 1'b0, 3'b011);
    add_row(WR, PRIV_M, 12'h3B1, 32'h0000_0900, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h3B1, 32'h0, 32'h0, 32'h0, 32'h0000_0801, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3B2, 32'h0000_0D00, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h3B2, 32'h0, 32'h0, 32'h0, 32'h0000_0C00, 1'b0, 3'b000);
    // RLB before any lock
    add_row(RST, PRIV_M, 12'h000, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h747, 32'h0000_0004, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h747, 32'h0, 32'h0, 32'h0, 32'h0000_0004, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3B0, 32'h0000_0100, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3A0, 32'h0000_0099, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(CK, PRIV_M, 12'h000, 32'h0, 32'h0000_0400, 32'h0000_0404, 32'h0, 1'b0, 3'b010);
    add_row(WR, PRIV_M, 12'h3A0, 32'h0000_001F, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h3A0, 32'h0, 32'h0, 32'h0, 32'h0000_001F, 1'b0, 3'b000);
    add_row(CK, PRIV_M, 12'h000, 32'h0, 32'h0000_0400, 32'h0000_0404, 32'h0, 1'b0, 3'b111);
    // RLB after a lock
    add_row(RST, PRIV_M, 12'h000, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3A0, 32'h0000_0099, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h747, 32'h0000_0004, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h747, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3A0, 32'h0000_001F, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h3A0, 32'h0, 32'h0, 32'h0, 32'h0000_0099, 1'b0, 3'b000);
    // MML with a locked region 0 and an unlocked region 1
    add_row(RST, PRIV_M, 12'h000, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h747, 32'h0000_0005, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h747, 32'h0, 32'h0, 32'h0, 32'h0000_0005, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3B0, 32'h0000_0100, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3B1, 32'h0000_0201, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3A0, 32'h0000_1B99, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3A0, 32'h009C_1B99, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h3A0, 32'h0, 32'h0, 32'h0, 32'h009C_1B99, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h747, 32'h0000_0000, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h747, 32'h0, 32'h0, 32'h0, 32'h0000_0001, 1'b0, 3'b000);
    add_row(WR, PRIV_M, 12'h3A0, 32'h9C9C_1B99, 32'h0, 32'h0, 32'h0, 1'b0, 3'b000);
    add_row(RD, PRIV_M, 12'h3A0, 32'h0, 32'h0, 32'h0, 32'h009C_1B99, 1'b0, 3'b000);
    add_row(CK, PRIV_M, 12'h000, 32'h0, 32'h0000_0400, 32'h0000_0400, 32'h0, 1'b0, 3'b010);
    add_row(CK, PRIV_U, 12'h000, 32'h0, 32'h0000_0400, 32'h0000_0400, 32'h0, 1'b0, 3'b000);
    add_row(CK, PRIV_M, 12'h000, 32'h0, 32'h0000_0800, 32'h0000_0800, 32'h0, 1'b0, 3'b000);
    add_row(CK, PRIV_U, 12'h000, 32'h0, 32'h0000_0800, 32'h0000_0800, 32'h0, 1'b0, 3'b011);
    add_row(CK, PRIV_M, 12'h000, 32'h0, 32'h0000_0004, 32'h0000_0008, 32'h0, 1'b0, 3'b100);
    add_row(CK, PRIV_M, 12'h000, 32'h0, 32'h0000_4000, 32'h0000_4000, 32'h0, 1'b0, 3'b011);
    add_row(CK, PRIV_U, 12'h000, 32'h0, 32'h0000_4000, 32'h0000_4000, 32'h0, 1'b0, 3'b000);

    cycle_limit = 4 * n_entries + 50;
    apply_reset();

    for (int i = 0; i < n_entries; i++) begin
      @(negedge clk_i);
      if (kind_tab[i] == RST) begin
        apply_reset();
      end else begin
        priv_lvl_i   = priv_tab[i];
        csr_we_i     = (kind_tab[i] == WR);
        csr_addr_i   = csr_tab[i];
        csr_wdata_i  = wdata_tab[i];
        fetch_addr_i = fetch_tab[i];
        data_addr_i  = data_tab[i];
        // Sample in the middle of the low phase
        #2;
        check_entry(i);
      end
    end
    @(negedge clk_i);
    csr_we_i = 1'b0;

    $display("%0d errors over %0d table entries", errors, n_entries);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
src/pmp_pkg.sv
src/pmp_state_if.sv
src/pmp_cfg_warl.sv
src/pmp_csr_regs.sv
src/pmp_region_match.sv
src/pmp_access_check.sv
src/pmp_unit.sv
verif/tb_pmp_unit.sv

//--- Bender.yml
package:
  name: pmp_unit

sources:
  - src/pmp_pkg.sv
  - src/pmp_state_if.sv
  - src/pmp_cfg_warl.sv
  - src/pmp_csr_regs.sv
  - src/pmp_region_match.sv
  - src/pmp_access_check.sv
  - src/pmp_unit.sv
  - target: test
    files:
      - verif/tb_pmp_unit.sv
